/* common/rv_back_cfg.svh */
//////////////////////////////////////////////////
// Width and depth settings for the back half
// DMEM_AW must equal log2 of DMEM_WORDS
// Only a 32-bit XLEN is supported by the memory
//////////////////////////////////////////////////
`ifndef RV_BACK_CFG_SVH
`define RV_BACK_CFG_SVH

`define RV_BACK_XLEN       32   // Data and address width
`define RV_BACK_DMEM_WORDS 256  // Data memory depth in words
`define RV_BACK_DMEM_AW    8    // Word address bits

`endif

/* common/rv_back_pkg.sv */
//////////////////////////////////////////////////
// Payload types shared by the stage registers
// Access size comes from func3[1:0], func3[2]
// marks an unsigned load
//////////////////////////////////////////////////
`default_nettype none

`include "rv_back_cfg.svh"

package rv_back_pkg;

    // Encoding follows func3[1:0] of the RV32I load and store group
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10
    } access_size_e;

    typedef struct packed {
        logic                      reg_write;
        logic                      mem_write;
        logic                      mem_to_reg;  // Load
        logic                      jump;
        logic [2:0]                func3;
        logic [4:0]                rd_addr;
        logic [`RV_BACK_XLEN-1:0]  pc_next;     // PC+4
        logic [`RV_BACK_XLEN-1:0]  alu;
        logic [`RV_BACK_XLEN-1:0]  data2;       // Store data
    } ex_mem_t;

    typedef struct packed {
        logic                      reg_write;   // Already cleared for x0
        logic [4:0]                rd_addr;
        logic [`RV_BACK_XLEN-1:0]  result;
    } mem_wb_t;

    function automatic access_size_e size_of_func3(input logic [2:0] func3);
        access_size_e size;
        case (func3[1:0])
            2'b00:   size = ACC_BYTE;
            2'b01:   size = ACC_HALF;
            default: size = ACC_WORD; // 2'b11 is not a legal RV32I access
        endcase
        return size;
    endfunction

    // LBU and LHU
    function automatic logic is_unsigned_load(input logic [2:0] func3);
        return func3[2];
    endfunction

endpackage

`default_nettype wire

/* design/stage_reg.sv */
//////////////////////////////////////////////////
// One pipeline register for any packed payload
// Flush only acts at an enabled edge
// Payload has no reset, only valid is cleared
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
    parameter type T_PAYLOAD = logic
) (
    input  wire logic     clk,
    input  wire logic     i_rst_n,
    input  wire logic     i_en,
    input  wire logic     i_flush,
    input  wire logic     i_valid,
    input  wire T_PAYLOAD i_payload,
    output logic          o_valid,
    output T_PAYLOAD      o_payload
);

    // Valid bit, a flushed instruction becomes a bubble
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_en) begin
            o_valid <= i_valid & ~i_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_payload <= i_payload; // Held while stalled
        end
    end

    // Downstream write enables depend on a clean valid
    a_valid_known : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !$isunknown(o_valid)
    ) else $error("stage_reg: o_valid unknown after reset");

endmodule

`default_nettype wire

/* memory/data_mem.sv */
//////////////////////////////////////////////////
// Word memory with byte lanes, async read
// Addresses wrap modulo the depth
// Misaligned stores are not trapped
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "rv_back_cfg.svh"

module data_mem (
    input  wire logic                           clk,
    input  wire logic                           i_we,
    input  wire logic [`RV_BACK_XLEN-1:0]       i_addr,
    input  wire rv_back_pkg::access_size_e      i_size,
    input  wire logic [`RV_BACK_XLEN-1:0]       i_wdata,
    output logic      [`RV_BACK_XLEN-1:0]       o_rdata
);

    localparam int NBYTES = `RV_BACK_XLEN / 8;

    logic [`RV_BACK_XLEN-1:0]   mem [0:`RV_BACK_DMEM_WORDS-1];
    logic [`RV_BACK_DMEM_AW-1:0] word_idx;
    logic [1:0]                 byte_off;
    logic [NBYTES-1:0]          byte_en;
    logic [`RV_BACK_XLEN-1:0]   lane_data;

    // Upper address bits past the depth are dropped
    assign word_idx = i_addr[`RV_BACK_DMEM_AW+1:2];
    assign byte_off = i_addr[1:0];

    // Copy store data into every lane it may land in
    always_comb begin
        case (i_size)
            rv_back_pkg::ACC_BYTE: begin
                lane_data = {NBYTES{i_wdata[7:0]}};
                byte_en   = 4'b0001 << byte_off;
            end
            rv_back_pkg::ACC_HALF: begin
                lane_data = {(NBYTES/2){i_wdata[15:0]}};
                byte_en   = 4'b0011 << {byte_off[1], 1'b0};
            end
            default: begin
                lane_data = i_wdata;
                byte_en   = '1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_we) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (byte_en[b]) begin
                    mem[word_idx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    assign o_rdata = mem[word_idx]; // Whole word, lane pick is done by the caller

    // Stores must sit on their natural boundary
    a_store_aligned : assert property (
        @(posedge clk)
        i_we |-> ((i_size == rv_back_pkg::ACC_WORD) ? (i_addr[1:0] == 2'b00) :
                  (i_size == rv_back_pkg::ACC_HALF) ? (i_addr[0] == 1'b0)    :
                                                      1'b1)
    ) else $error("data_mem: misaligned store at %h", i_addr);

endmodule

`default_nettype wire

/* memory/mem_access.sv */
//////////////////////////////////////////////////
// Memory stage, combinational apart from the
// store at the enabled edge
// A frozen store is not repeated during a stall
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "rv_back_cfg.svh"

module mem_access (
    input  wire logic                 clk,
    input  wire logic                 i_en,
    input  wire logic                 i_valid,
    input  wire rv_back_pkg::ex_mem_t i_ex_mem,
    output rv_back_pkg::mem_wb_t      o_mem_wb
);

    rv_back_pkg::access_size_e acc_size;
    logic                      load_unsigned;
    logic                      mem_we;
    logic [`RV_BACK_XLEN-1:0]  rd_word;
    logic [`RV_BACK_XLEN-1:0]  rd_shift;
    logic [`RV_BACK_XLEN-1:0]  load_data;

    assign acc_size      = rv_back_pkg::size_of_func3(i_ex_mem.func3);
    assign load_unsigned = rv_back_pkg::is_unsigned_load(i_ex_mem.func3);

    // Gated by i_en so a held store writes once
    assign mem_we = i_valid & i_ex_mem.mem_write & i_en;

    data_mem u_dmem (
        .clk     (clk),
        .i_we    (mem_we),
        .i_addr  (i_ex_mem.alu),
        .i_size  (acc_size),
        .i_wdata (i_ex_mem.data2),
        .o_rdata (rd_word)
    );

    // Bring the addressed lane down to bit 0
    assign rd_shift = rd_word >> {i_ex_mem.alu[1:0], 3'b000};

    always_comb begin
        case (acc_size)
            rv_back_pkg::ACC_BYTE: begin
                if (load_unsigned) begin
                    load_data = {{(`RV_BACK_XLEN-8){1'b0}}, rd_shift[7:0]};
                end else begin
                    load_data = {{(`RV_BACK_XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
                end
            end
            rv_back_pkg::ACC_HALF: begin
                if (load_unsigned) begin
                    load_data = {{(`RV_BACK_XLEN-16){1'b0}}, rd_shift[15:0]};
                end else begin
                    load_data = {{(`RV_BACK_XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
                end
            end
            default: load_data = rd_shift;
        endcase
    end

    // Writeback select, jump has priority
    always_comb begin
        o_mem_wb.rd_addr   = i_ex_mem.rd_addr;
        o_mem_wb.reg_write = i_ex_mem.reg_write & (i_ex_mem.rd_addr != 5'd0); // x0 stays zero
        if (i_ex_mem.jump) begin
            o_mem_wb.result = i_ex_mem.pc_next;
        end else if (i_ex_mem.mem_to_reg) begin
            o_mem_wb.result = load_data;
        end else begin
            o_mem_wb.result = i_ex_mem.alu;
        end
    end

    // Decode never marks one instruction as both load and store
    a_no_load_store : assert property (
        @(posedge clk)
        i_valid |-> !(i_ex_mem.mem_write && i_ex_mem.mem_to_reg)
    ) else $error("mem_access: load and store set together");

endmodule

`default_nettype wire

/* design/rv_back_top.sv */
//////////////////////////////////////////////////
// EX/MEM, memory stage and MEM/WB of an RV32I
// Two enabled edges from input to o_wb_*
// No back-pressure besides the global i_en
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "rv_back_cfg.svh"

module rv_back_top (
    input  wire logic                     clk,
    input  wire logic                     i_rst_n,
    input  wire logic                     i_en,      // Global stall enable
    input  wire logic                     i_flush,   // Bubble into EX/MEM
    input  wire logic                     i_valid,
    input  wire logic                     i_reg_write,
    input  wire logic                     i_mem_write,
    input  wire logic                     i_mem_to_reg,
    input  wire logic                     i_jump,
    input  wire logic [2:0]               i_func3,
    input  wire logic [4:0]               i_rd_addr,
    input  wire logic [`RV_BACK_XLEN-1:0] i_pc_next,
    input  wire logic [`RV_BACK_XLEN-1:0] i_alu,
    input  wire logic [`RV_BACK_XLEN-1:0] i_data2,
    output logic                          o_wb_we,
    output logic      [4:0]               o_wb_rd_addr,
    output logic      [`RV_BACK_XLEN-1:0] o_wb_data,
    output logic                          o_fwd_mem_reg_write,
    output logic      [4:0]               o_fwd_mem_rd_addr,
    output logic      [`RV_BACK_XLEN-1:0] o_fwd_mem_alu
);

    rv_back_pkg::ex_mem_t ex_mem_d;
    rv_back_pkg::ex_mem_t ex_mem_q;
    logic                 ex_mem_valid;
    rv_back_pkg::mem_wb_t mem_wb_d;
    rv_back_pkg::mem_wb_t mem_wb_q;
    logic                 mem_wb_valid;

    always_comb begin
        ex_mem_d.reg_write  = i_reg_write;
        ex_mem_d.mem_write  = i_mem_write;
        ex_mem_d.mem_to_reg = i_mem_to_reg;
        ex_mem_d.jump       = i_jump;
        ex_mem_d.func3      = i_func3;
        ex_mem_d.rd_addr    = i_rd_addr;
        ex_mem_d.pc_next    = i_pc_next;
        ex_mem_d.alu        = i_alu;
        ex_mem_d.data2      = i_data2;
    end

    stage_reg #(
        .T_PAYLOAD (rv_back_pkg::ex_mem_t)
    ) u_ex_mem (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_en      (i_en),
        .i_flush   (i_flush),
        .i_valid   (i_valid),
        .i_payload (ex_mem_d),
        .o_valid   (ex_mem_valid),
        .o_payload (ex_mem_q)
    );

    mem_access u_mem (
        .clk      (clk),
        .i_en     (i_en),
        .i_valid  (ex_mem_valid),
        .i_ex_mem (ex_mem_q),
        .o_mem_wb (mem_wb_d)
    );

    stage_reg #(
        .T_PAYLOAD (rv_back_pkg::mem_wb_t)
    ) u_mem_wb (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_en      (i_en),
        .i_flush   (1'b0),   // Flush only reaches EX/MEM
        .i_valid   (ex_mem_valid),
        .i_payload (mem_wb_d),
        .o_valid   (mem_wb_valid),
        .o_payload (mem_wb_q)
    );

    assign o_wb_we      = mem_wb_valid & mem_wb_q.reg_write;
    assign o_wb_rd_addr = mem_wb_q.rd_addr;
    assign o_wb_data    = mem_wb_q.result;

    // Forwarding taps from the MEM stage
    assign o_fwd_mem_reg_write = ex_mem_valid & ex_mem_q.reg_write;
    assign o_fwd_mem_rd_addr   = ex_mem_q.rd_addr;
    assign o_fwd_mem_alu       = ex_mem_q.alu;

endmodule

`default_nettype wire

/* bench/tb_rv_back.sv */
//////////////////////////////////////////////////
// Testbench for rv_back_top with a shadow pipeline
// Memory is filled with word stores before loads
// Every load and store uses an aligned address
//////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "rv_back_cfg.svh"

module tb_rv_back;

    localparam int XLEN  = `RV_BACK_XLEN;
    localparam int WORDS = `RV_BACK_DMEM_WORDS;
    localparam int AW    = `RV_BACK_DMEM_AW;

    logic            clk;
    logic            i_rst_n;
    logic            i_en;
    logic            i_flush;
    logic            i_valid;
    logic            i_reg_write;
    logic            i_mem_write;
    logic            i_mem_to_reg;
    logic            i_jump;
    logic [2:0]      i_func3;
    logic [4:0]      i_rd_addr;
    logic [XLEN-1:0] i_pc_next;
    logic [XLEN-1:0] i_alu;
    logic [XLEN-1:0] i_data2;
    logic            o_wb_we;
    logic [4:0]      o_wb_rd_addr;
    logic [XLEN-1:0] o_wb_data;
    logic            o_fwd_mem_reg_write;
    logic [4:0]      o_fwd_mem_rd_addr;
    logic [XLEN-1:0] o_fwd_mem_alu;

    // m1 mirrors EX/MEM and m2 mirrors MEM/WB in the reference model
    logic [XLEN-1:0] model_mem [0:WORDS-1];
    logic            m1_valid;
    logic            m1_reg_write;
    logic            m1_mem_write;
    logic            m1_mem_to_reg;
    logic            m1_jump;
    logic [2:0]      m1_func3;
    logic [4:0]      m1_rd_addr;
    logic [XLEN-1:0] m1_pc_next;
    logic [XLEN-1:0] m1_alu;
    logic [XLEN-1:0] m1_data2;
    logic            m2_valid;
    logic            m2_we;
    logic            m2_load;
    logic [4:0]      m2_rd_addr;
    logic [XLEN-1:0] m2_data;
    logic            exp_we;

    logic [31:0]     rng;
    int              error_count;
    int              wb_checked;
    int              loads_checked;
    int              stalls_done;
    int              flushes_done;

    rv_back_top uut (
        .clk                 (clk),
        .i_rst_n             (i_rst_n),
        .i_en                (i_en),
        .i_flush             (i_flush),
        .i_valid             (i_valid),
        .i_reg_write         (i_reg_write),
        .i_mem_write         (i_mem_write),
        .i_mem_to_reg        (i_mem_to_reg),
        .i_jump              (i_jump),
        .i_func3             (i_func3),
        .i_rd_addr           (i_rd_addr),
        .i_pc_next           (i_pc_next),
        .i_alu               (i_alu),
        .i_data2             (i_data2),
        .o_wb_we             (o_wb_we),
        .o_wb_rd_addr        (o_wb_rd_addr),
        .o_wb_data           (o_wb_data),
        .o_fwd_mem_reg_write (o_fwd_mem_reg_write),
        .o_fwd_mem_rd_addr   (o_fwd_mem_rd_addr),
        .o_fwd_mem_alu       (o_fwd_mem_alu)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Fill value mixes every address bit
    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return (addr ^ 32'h5a5a_0f0f) * 32'h9e37_79b1 + {addr[15:0], addr[31:16]};
    endfunction

    // New word after a store of the given size at byte offset off
    function automatic logic [31:0] merge_store(input logic [31:0] old_word,
                                                input logic [2:0]  func3,
                                                input logic [1:0]  off,
                                                input logic [31:0] data);
        logic [31:0] w;
        w = old_word;
        case (rv_back_pkg::size_of_func3(func3))
            rv_back_pkg::ACC_BYTE: begin
                case (off)
                    2'd0:    w[7:0]   = data[7:0];
                    2'd1:    w[15:8]  = data[7:0];
                    2'd2:    w[23:16] = data[7:0];
                    default: w[31:24] = data[7:0];
                endcase
            end
            rv_back_pkg::ACC_HALF: begin
                if (off[1]) w[31:16] = data[15:0];
                else        w[15:0]  = data[15:0];
            end
            default: w = data;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] extract_load(input logic [31:0] word,
                                                 input logic [2:0]  func3,
                                                 input logic [1:0]  off);
        logic [7:0]  b;
        logic [15:0] h;
        logic        uns;
        logic [31:0] r;
        uns = rv_back_pkg::is_unsigned_load(func3);
        case (off)
            2'd0:    b = word[7:0];
            2'd1:    b = word[15:8];
            2'd2:    b = word[23:16];
            default: b = word[31:24];
        endcase
        h = off[1] ? word[31:16] : word[15:0];
        case (rv_back_pkg::size_of_func3(func3))
            rv_back_pkg::ACC_BYTE: r = uns ? {24'd0, b} : {{24{b[7]}}, b};
            rv_back_pkg::ACC_HALF: r = uns ? {16'd0, h} : {{16{h[15]}}, h};
            default:               r = word;
        endcase
        return r;
    endfunction

    // Clears the offset bits below the natural boundary
    function automatic logic [31:0] align_addr(input logic [31:0] raw, input logic [2:0] func3);
        case (rv_back_pkg::size_of_func3(func3))
            rv_back_pkg::ACC_BYTE: return raw;
            rv_back_pkg::ACC_HALF: return {raw[31:1], 1'b0};
            default:               return {raw[31:2], 2'b00};
        endcase
    endfunction

    task automatic draw_random(output logic [31:0] v);
        rng = lcg_step(rng);
        v   = rng;
    endtask

    task automatic flag_error(input string msg);
        error_count++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // Shadow pipeline advances only on enabled edges
    always @(posedge clk) begin
        if (!i_rst_n) begin
            m1_valid <= 1'b0;
            m2_valid <= 1'b0;
        end else if (i_en) begin
            if (m1_valid && m1_mem_write) begin
                model_mem[m1_alu[AW+1:2]] <= merge_store(model_mem[m1_alu[AW+1:2]],
                                                         m1_func3, m1_alu[1:0], m1_data2);
            end
            m2_valid   <= m1_valid;
            m2_we      <= m1_reg_write && (m1_rd_addr != 5'd0);
            m2_load    <= m1_mem_to_reg && !m1_jump;
            m2_rd_addr <= m1_rd_addr;
            if (m1_jump) begin
                m2_data <= m1_pc_next;
            end else if (m1_mem_to_reg) begin
                m2_data <= extract_load(model_mem[m1_alu[AW+1:2]], m1_func3, m1_alu[1:0]);
            end else begin
                m2_data <= m1_alu;
            end
            m1_valid      <= i_valid && !i_flush;   // Flushed entry is a bubble
            m1_reg_write  <= i_reg_write;
            m1_mem_write  <= i_mem_write;
            m1_mem_to_reg <= i_mem_to_reg;
            m1_jump       <= i_jump;
            m1_func3      <= i_func3;
            m1_rd_addr    <= i_rd_addr;
            m1_pc_next    <= i_pc_next;
            m1_alu        <= i_alu;
            m1_data2      <= i_data2;
        end
    end

    assign exp_we = m2_valid & m2_we;

    always @(posedge clk) begin
        if (i_rst_n && exp_we) begin
            wb_checked++;
            if (m2_load) begin
                loads_checked++;
            end
        end
        if (i_rst_n && !i_en && exp_we) begin
            stalls_done++;   // Stalled edge with a writeback on the outputs
        end
        if (i_rst_n && i_en && i_valid && i_flush) begin
            flushes_done++;
        end
    end

    a_reset_quiet : assert property (
        @(posedge clk) !i_rst_n |=> (!o_wb_we && !o_fwd_mem_reg_write)
    ) else flag_error("write enable high during reset");

    a_wb_we : assert property (
        @(posedge clk) disable iff (!i_rst_n) o_wb_we === exp_we
    ) else flag_error("o_wb_we differs from the model");

    a_wb_value : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        exp_we |-> (o_wb_rd_addr === m2_rd_addr && o_wb_data === m2_data)
    ) else flag_error("o_wb_rd_addr or o_wb_data differs from the model");

    a_fwd_we : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_fwd_mem_reg_write === (m1_valid && m1_reg_write)
    ) else flag_error("o_fwd_mem_reg_write differs from the model");

    a_fwd_value : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        m1_valid |-> (o_fwd_mem_rd_addr === m1_rd_addr && o_fwd_mem_alu === m1_alu)
    ) else flag_error("forwarding tap differs from the EX/MEM entry");

    // Outputs freeze across a stalled edge
    a_stall_hold : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !i_en |=> ($stable(o_wb_we) && $stable(o_wb_rd_addr) && $stable(o_wb_data))
    ) else flag_error("o_wb outputs changed during a stall");

    // Drives one instruction per call on the falling edge
    task automatic drive_instr(input logic        flush,
                               input logic        reg_write,
                               input logic        mem_write,
                               input logic        mem_to_reg,
                               input logic        jump,
                               input logic [2:0]  func3,
                               input logic [4:0]  rd,
                               input logic [31:0] pc_next,
                               input logic [31:0] alu,
                               input logic [31:0] data2);
        i_en         = 1'b1;
        i_valid      = 1'b1;
        i_flush      = flush;
        i_reg_write  = reg_write;
        i_mem_write  = mem_write;
        i_mem_to_reg = mem_to_reg;
        i_jump       = jump;
        i_func3      = func3;
        i_rd_addr    = rd;
        i_pc_next    = pc_next;
        i_alu        = alu;
        i_data2      = data2;
        @(negedge clk);
    endtask

    task automatic alu_op(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] junk;
        draw_random(junk);
        drive_instr(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 3'b000, rd, junk, value, ~junk);
    endtask

    task automatic jump_op(input logic [4:0] rd, input logic [31:0] pc_next);
        logic [31:0] target;
        draw_random(target);
        drive_instr(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 3'b000, rd, pc_next, target, 32'd0);
    endtask

    task automatic store_op(input logic        flush,
                            input logic [2:0]  func3,
                            input logic [31:0] addr,
                            input logic [31:0] data);
        drive_instr(flush, 1'b0, 1'b1, 1'b0, 1'b0, func3, 5'd7, 32'd0, addr, data);
    endtask

    task automatic load_op(input logic [2:0] func3, input logic [4:0] rd, input logic [31:0] addr);
        drive_instr(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, func3, rd, 32'd0, addr, 32'd0);
    endtask

    // Stall with garbage on the inputs, which must be ignored
    task automatic stall_cycles(input int n);
        logic [31:0] junk;
        for (int k = 0; k < n; k++) begin
            draw_random(junk);
            i_en    = 1'b0;
            i_valid = 1'b1;
            i_alu   = junk;
            i_rd_addr = junk[4:0];
            @(negedge clk);
        end
        i_en = 1'b1;
    endtask

    task automatic wait_drain();
        int n;
        n       = 0;
        i_en    = 1'b1;
        i_valid = 1'b0;
        i_flush = 1'b0;
        while ((m1_valid || m2_valid) && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (m1_valid || m2_valid) begin
            $display("Timeout: pipeline did not drain within 20 cycles");
            error_count++;
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] d;
        logic [31:0] addr;
        logic [31:0] laddr;
        logic [2:0]  f3;
        logic [2:0]  load_f3 [0:4];
        logic [4:0]  rd;

        load_f3[0] = 3'b000;   // LB
        load_f3[1] = 3'b001;   // LH
        load_f3[2] = 3'b010;   // LW
        load_f3[3] = 3'b100;   // LBU
        load_f3[4] = 3'b101;   // LHU
        rng           = 32'ha397797f;
        error_count   = 0;
        wb_checked    = 0;
        loads_checked = 0;
        stalls_done   = 0;
        flushes_done  = 0;
        i_rst_n       = 1'b0;
        i_en          = 1'b1;
        i_flush       = 1'b0;
        i_valid       = 1'b0;
        i_reg_write   = 1'b0;
        i_mem_write   = 1'b0;
        i_mem_to_reg  = 1'b0;
        i_jump        = 1'b0;
        i_func3       = 3'b000;
        i_rd_addr     = 5'd0;
        i_pc_next     = '0;
        i_alu         = '0;
        i_data2       = '0;
        repeat (10) @(negedge clk);
        i_rst_n = 1'b1;

        // Back-to-back ALU results and jumps including x0
        for (int k = 0; k < 24; k++) begin
            draw_random(r);
            draw_random(d);
            if (r[1:0] == 2'b11) jump_op(r[12:8], d);
            else                 alu_op(r[12:8], d);
        end
        alu_op(5'd0, 32'hdead_beef);
        jump_op(5'd0, 32'h0000_1004);
        wait_drain();

        for (int w = 0; w < WORDS; w++) begin
            addr = {22'd0, w[7:0], 2'b00};
            store_op(1'b0, 3'b010, addr, fill_pattern(addr));
        end

        // Random store, then every load kind on the same word
        for (int k = 0; k < 40; k++) begin
            draw_random(r);
            draw_random(d);
            f3   = {1'b0, (r[1:0] == 2'b11) ? 2'b10 : r[1:0]};
            addr = align_addr(r, f3);
            store_op(1'b0, f3, addr, d);
            for (int j = 0; j < 5; j++) begin
                draw_random(r2);
                laddr = align_addr({r2[31:10], addr[9:2], r2[1:0]}, load_f3[j]);
                rd    = (r2[16:12] == 5'd0) ? 5'd1 : r2[16:12];
                load_op(load_f3[j], rd, laddr);
            end
        end

        // Stall with a store held in EX/MEM
        draw_random(r);
        draw_random(d);
        store_op(1'b0, 3'b000, r, d);
        stall_cycles(5);
        alu_op(5'd3, d ^ 32'h0f0f_0f0f);
        stall_cycles(3);
        load_op(3'b100, 5'd9, r);
        load_op(3'b010, 5'd10, {r[31:2], 2'b00});
        jump_op(5'd11, 32'h0000_2000);

        // Flushed store and ALU op leave no trace
        draw_random(r);
        addr = {r[31:2], 2'b00};
        store_op(1'b1, 3'b010, addr, ~r);
        load_op(3'b010, 5'd12, addr);
        drive_instr(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 3'b000, 5'd13, 32'd0, r, 32'd0);
        alu_op(5'd14, r);
        wait_drain();
        @(negedge clk);

        if (wb_checked == 0 || loads_checked == 0) begin
            $display("Stimulus never reached the writeback or load checks");
            error_count++;
        end
        if (stalls_done == 0 || flushes_done == 0) begin
            $display("Stimulus never reached the stall or flush checks");
            error_count++;
        end
        $display("Summary: %0d errors, %0d writebacks, %0d loads, %0d stalls, %0d flushes",
                 error_count, wb_checked, loads_checked, stalls_done, flushes_done);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rv_back.f */
+incdir+common
common/rv_back_pkg.sv
design/stage_reg.sv
memory/data_mem.sv
memory/mem_access.sv
design/rv_back_top.sv
bench/tb_rv_back.sv

/* Makefile */
# Verilator build and run for rv_back
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_rv_back
FILELIST  ?= rv_back.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_LINE ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_LINE)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
